// File: sim.f
+incdir+verilog
+incdir+dv
verilog/axi_lite_pkg.sv
verilog/reg_bank_pkg.sv
verilog/axi_write_channel.sv
verilog/axi_read_channel.sv
verilog/reg_bank.sv
verilog/axil_reg_bank.sv
dv/tb_axil_reg_bank.sv

// File: dv/tb_axil_tasks.svh
`ifndef TB_AXIL_TASKS_SVH
`define TB_AXIL_TASKS_SVH

task automatic check_data(input string name, input axil_data_t expected,
                          input axil_data_t actual);
  if (actual !== expected) begin
    abort_run($sformatf("Fail %s: expected 0x%h, actual 0x%h", name, expected, actual));
  end
endtask

task automatic check_resp(input string name, input axil_resp_t expected,
                          input axil_resp_t actual);
  if (actual !== expected) begin
    abort_run($sformatf("Fail %s: expected 0x%h, actual 0x%h", name, expected, actual));
  end
endtask

task automatic check_flag(input string name, input logic expected, input logic actual);
  if (actual !== expected) begin
    abort_run($sformatf("Fail %s: expected 0x%h, actual 0x%h", name, expected, actual));
  end
endtask

// Returns at the edge where AW and W transfer
task automatic wait_write_accept();
  do @(posedge S_AXI_ACLK); while (!s_axi_awready);
  check_flag("WREADY", 1'b1, s_axi_wready);
endtask

task automatic axi_write(input axil_addr_t addr, input axil_data_t data,
                         input axil_strb_t strb, input int stall);
  reg_index_t idx;
  idx = reg_index_t'(addr >> `REG_INDEX_LSB);
  s_axi_awaddr  = addr;
  s_axi_awvalid = 1'b1;
  s_axi_wdata   = data;
  s_axi_wstrb   = strb;
  s_axi_wvalid  = 1'b1;
  s_axi_bready  = (stall == 0);
  wait_write_accept();
  model_regs[idx] = merge_strobed(model_regs[idx], data, strb);
  writes_issued++;
  if (stall > 0) begin
    // Same write kept on AW and W while the response is held
    repeat (stall) begin
      @(posedge S_AXI_ACLK);
      check_flag("BVALID", 1'b1, s_axi_bvalid);
      check_flag("AWREADY", 1'b0, s_axi_awready);
      check_flag("WREADY", 1'b0, s_axi_wready);
    end
    #1;
    s_axi_bready = 1'b1;
    wait_write_accept();   // Repeat lands once B is free
    writes_issued++;
  end
  #1;
  s_axi_awvalid = 1'b0;
  s_axi_wvalid  = 1'b0;
  do @(posedge S_AXI_ACLK); while (!(s_axi_bvalid && s_axi_bready));
  #1;
endtask

task automatic axi_read(input axil_addr_t addr, input int stall);
  axil_data_t expect_word;
  expect_word = expected_read(reg_index_t'(addr >> `REG_INDEX_LSB));
  rd_expect.push_back(expect_word);
  reads_issued++;
  s_axi_araddr  = addr;
  s_axi_arvalid = 1'b1;
  s_axi_rready  = (stall == 0);
  do @(posedge S_AXI_ACLK); while (!s_axi_arready);
  if (stall > 0) begin
    // Same read kept on AR while RDATA is held
    repeat (stall) begin
      @(posedge S_AXI_ACLK);
      check_flag("RVALID", 1'b1, s_axi_rvalid);
      check_flag("ARREADY", 1'b0, s_axi_arready);
      check_data("RDATA", expect_word, s_axi_rdata);
    end
    #1;
    s_axi_rready = 1'b1;
    rd_expect.push_back(expect_word);
    reads_issued++;
    do @(posedge S_AXI_ACLK); while (!s_axi_arready);   // Repeat lands once R is free
  end
  #1;
  s_axi_arvalid = 1'b0;
  do @(posedge S_AXI_ACLK); while (!(s_axi_rvalid && s_axi_rready));
  #1;
endtask

`endif

// File: dv/tb_axil_reg_bank.sv
`timescale 1ns/1ps
`include "axil_reg_settings.svh"

module tb_axil_reg_bank
  import axi_lite_pkg::*;
  import reg_bank_pkg::*;
();

  localparam int MAX_STALL   = 7;
  localparam int PART_COUNT  = 14;   // Strobe patterns 1 to 14 leave a lane out
  localparam int STALL_COUNT = 8;
  localparam int MIX_COUNT   = 200;
  localparam int TXN_COUNT   = 4 * `REG_COUNT + 2 * PART_COUNT + 2 * STALL_COUNT + MIX_COUNT;
  // A stalled transfer is sent twice and waits out the stall
  localparam int TXN_CYCLES  = 2 * (4 + MAX_STALL);
  localparam int TIMEOUT_CYCLES = TXN_COUNT * TXN_CYCLES + 100;

  logic       S_AXI_ACLK;
  logic       S_AXI_ARESETN;
  axil_addr_t s_axi_awaddr;
  logic       s_axi_awvalid;
  logic       s_axi_awready;
  axil_data_t s_axi_wdata;
  axil_strb_t s_axi_wstrb;
  logic       s_axi_wvalid;
  logic       s_axi_wready;
  axil_resp_t s_axi_bresp;
  logic       s_axi_bvalid;
  logic       s_axi_bready;
  axil_addr_t s_axi_araddr;
  logic       s_axi_arvalid;
  logic       s_axi_arready;
  axil_data_t s_axi_rdata;
  axil_resp_t s_axi_rresp;
  logic       s_axi_rvalid;
  logic       s_axi_rready;

  logic [31:0] lcg_state = 32'hf9df;
  reg_word_u   model_regs [`REG_COUNT];
  axil_data_t  rd_expect [$];   // Expected RDATA in issue order
  int          writes_issued = 0;
  int          reads_issued = 0;
  int          b_count = 0;
  int          r_count = 0;
  int          cycle_count = 0;

  axil_reg_bank i_axil_reg_bank (.*);

  initial begin
    S_AXI_ACLK = 1'b0;
    forever #10 S_AXI_ACLK = ~S_AXI_ACLK;
  end

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Regression failed");
    $fatal(1);
  endtask

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Only lanes with their strobe set take the new byte
  function automatic reg_word_u merge_strobed(input reg_word_u old_word, input axil_data_t data,
                                              input axil_strb_t strb);
    reg_word_u new_word;
    reg_word_u result;
    new_word.word = data;
    result = old_word;
    for (int b = 0; b < `AXIL_STRB_WIDTH; b++) begin
      if (strb[b]) begin
        result.bytes[b] = new_word.bytes[b];
      end
    end
    return result;
  endfunction

  function automatic axil_data_t expected_read(input reg_index_t idx);
    return model_regs[idx].word;
  endfunction

  function automatic axil_addr_t reg_addr(input int idx);
    return axil_addr_t'(idx << `REG_INDEX_LSB);
  endfunction

  `include "tb_axil_tasks.svh"

  always @(posedge S_AXI_ACLK) begin
    if (S_AXI_ARESETN && s_axi_rvalid && s_axi_rready) begin
      if (rd_expect.size() == 0) begin
        abort_run("An R transfer arrived with no read outstanding");
      end else begin
        check_data("RDATA", rd_expect.pop_front(), s_axi_rdata);
        check_resp("RRESP", OKAY, s_axi_rresp);
        r_count++;
      end
    end
    if (S_AXI_ARESETN && s_axi_bvalid && s_axi_bready) begin
      check_resp("BRESP", OKAY, s_axi_bresp);
      b_count++;
    end
  end

  always @(posedge S_AXI_ACLK) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      abort_run("Timeout: the test sequence did not finish within the cycle limit");
    end
  end

  initial begin
    logic [31:0] r;
    axil_addr_t  addr;
    axil_data_t  data;
    int          stall;
    S_AXI_ARESETN = 1'b0;
    s_axi_awaddr  = '0;
    s_axi_awvalid = 1'b0;
    s_axi_wdata   = '0;
    s_axi_wstrb   = '0;
    s_axi_wvalid  = 1'b0;
    s_axi_bready  = 1'b1;
    s_axi_araddr  = '0;
    s_axi_arvalid = 1'b0;
    s_axi_rready  = 1'b1;
    for (int i = 0; i < `REG_COUNT; i++) begin
      model_regs[i].word = '0;
    end
    repeat (2) @(posedge S_AXI_ACLK);
    #1;
    S_AXI_ARESETN = 1'b1;

    for (int i = 0; i < `REG_COUNT; i++) begin
      axi_read(reg_addr(i), 0);   // Reset values
    end
    for (int i = 0; i < `REG_COUNT; i++) begin
      data = lcg_next();
      axi_write(reg_addr(i), data, '1, 0);
    end
    for (int i = 0; i < `REG_COUNT; i++) begin
      axi_read(reg_addr(i), 0);
    end

    for (int i = 0; i < PART_COUNT; i++) begin
      r = lcg_next();
      addr = axil_addr_t'(r >> 25);
      data = lcg_next();
      axi_write(addr, data, axil_strb_t'(i + 1), 0);
      axi_read(addr, 0);
    end

    for (int i = 0; i < STALL_COUNT; i++) begin
      r = lcg_next();
      addr = axil_addr_t'(r >> 25);
      stall = 1 + int'((r >> 16) % MAX_STALL);
      data = lcg_next();
      axi_write(addr, data, '1, stall);
      axi_read(addr, stall);
    end

    for (int i = 0; i < MIX_COUNT; i++) begin
      r = lcg_next();
      stall = int'((r >> 16) % (MAX_STALL + 1));
      addr = axil_addr_t'(lcg_next() >> 25);
      if (r[31]) begin
        data = lcg_next();
        axi_write(addr, data, axil_strb_t'(r >> 26), stall);
      end else begin
        axi_read(addr, stall);
      end
    end

    for (int i = 0; i < `REG_COUNT; i++) begin
      axi_read(reg_addr(i), 0);   // Neighbours untouched
    end

    repeat (4) @(posedge S_AXI_ACLK);
    if (b_count == writes_issued && r_count == reads_issued && rd_expect.size() == 0) begin
      $display("Regression passed");
      $finish;
    end else begin
      abort_run("The number of B or R transfers does not match the transactions sent");
    end
  end

endmodule

// File: verilog/axil_reg_bank.sv
`timescale 1ns/1ps

module axil_reg_bank
  import axi_lite_pkg::*;
  import reg_bank_pkg::*;
(
  input  logic       S_AXI_ACLK,
  input  logic       S_AXI_ARESETN,
  input  axil_addr_t s_axi_awaddr,
  input  logic       s_axi_awvalid,
  output logic       s_axi_awready,
  input  axil_data_t s_axi_wdata,
  input  axil_strb_t s_axi_wstrb,
  input  logic       s_axi_wvalid,
  output logic       s_axi_wready,
  output axil_resp_t s_axi_bresp,
  output logic       s_axi_bvalid,
  input  logic       s_axi_bready,
  input  axil_addr_t s_axi_araddr,
  input  logic       s_axi_arvalid,
  output logic       s_axi_arready,
  output axil_data_t s_axi_rdata,
  output axil_resp_t s_axi_rresp,
  output logic       s_axi_rvalid,
  input  logic       s_axi_rready
);

  // Write command
  logic       wr_en;
  reg_index_t wr_index;
  axil_data_t wr_data;
  axil_strb_t wr_strb;

  // Read lookup
  reg_index_t rd_index;
  axil_data_t rd_word;

  axi_write_channel i_write_channel (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .awaddr        (s_axi_awaddr),
    .awvalid       (s_axi_awvalid),
    .awready       (s_axi_awready),
    .wdata         (s_axi_wdata),
    .wstrb         (s_axi_wstrb),
    .wvalid        (s_axi_wvalid),
    .wready        (s_axi_wready),
    .bvalid        (s_axi_bvalid),
    .bresp         (s_axi_bresp),
    .bready        (s_axi_bready),
    .wr_en         (wr_en),
    .wr_index      (wr_index),
    .wr_data       (wr_data),
    .wr_strb       (wr_strb)
  );

  axi_read_channel i_read_channel (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .araddr        (s_axi_araddr),
    .arvalid       (s_axi_arvalid),
    .arready       (s_axi_arready),
    .rvalid        (s_axi_rvalid),
    .rresp         (s_axi_rresp),
    .rdata         (s_axi_rdata),
    .rready        (s_axi_rready),
    .rd_index      (rd_index),
    .rd_word       (rd_word)
  );

  reg_bank i_reg_bank (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .wr_en         (wr_en),
    .wr_index      (wr_index),
    .wr_data       (wr_data),
    .wr_strb       (wr_strb),
    .rd_index      (rd_index),
    .rd_word       (rd_word)
  );

endmodule

// File: verilog/reg_bank.sv
`timescale 1ns/1ps
`include "axil_reg_settings.svh"

module reg_bank
  import axi_lite_pkg::*;
  import reg_bank_pkg::*;
(
  input  logic       S_AXI_ACLK,
  input  logic       S_AXI_ARESETN,
  input  logic       wr_en,
  input  reg_index_t wr_index,
  input  axil_data_t wr_data,
  input  axil_strb_t wr_strb,
  input  reg_index_t rd_index,
  output axil_data_t rd_word
);

  reg_word_u regs [`REG_COUNT];
  reg_word_u wr_word;   // Incoming data split into lanes

  assign wr_word.word = wr_data;

  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      for (int r = 0; r < `REG_COUNT; r++) begin
        regs[r].word <= '0;
      end
    end else begin
      if (wr_en) begin
        for (int b = 0; b < `AXIL_STRB_WIDTH; b++) begin
          if (wr_strb[b]) begin
            regs[wr_index].bytes[b] <= wr_word.bytes[b];   // Unstrobed lanes keep value
          end
        end
      end
    end
  end

  // Read mux
  assign rd_word = regs[rd_index].word;

endmodule

// File: verilog/axi_read_channel.sv
`timescale 1ns/1ps
`include "axil_reg_settings.svh"

module axi_read_channel
  import axi_lite_pkg::*;
  import reg_bank_pkg::*;
(
  input  logic       S_AXI_ACLK,
  input  logic       S_AXI_ARESETN,
  input  axil_addr_t araddr,
  input  logic       arvalid,
  output logic       arready,
  output logic       rvalid,
  output axil_resp_t rresp,
  output axil_data_t rdata,
  input  logic       rready,
  output reg_index_t rd_index,
  input  axil_data_t rd_word
);

  logic       arready_q;
  logic       rvalid_q;
  axil_data_t rdata_q;
  axil_addr_t araddr_q;
  logic       start;
  logic       rd_en;

  // New read only once R is free
  assign start = !arready_q && arvalid && (!rvalid_q || rready);
  assign rd_en = arready_q && arvalid;

  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      arready_q <= 1'b0;
    end else begin
      arready_q <= start;
    end
  end

  always_ff @(posedge S_AXI_ACLK) begin
    if (start) begin
      araddr_q <= araddr;
    end
  end

  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      rvalid_q <= 1'b0;
      rdata_q  <= '0;
    end else begin
      if (rd_en) begin
        rvalid_q <= 1'b1;
        rdata_q  <= rd_word;   // Sampled once, held under stall
      end else if (rready) begin
        rvalid_q <= 1'b0;
      end
    end
  end

  assign rd_index = araddr_q[`REG_INDEX_LSB +: $bits(reg_index_t)];
  assign arready  = arready_q;
  assign rvalid   = rvalid_q;
  assign rdata    = rdata_q;
  assign rresp    = OKAY;

endmodule

// File: verilog/axi_write_channel.sv
`timescale 1ns/1ps
`include "axil_reg_settings.svh"

module axi_write_channel
  import axi_lite_pkg::*;
  import reg_bank_pkg::*;
(
  input  logic       S_AXI_ACLK,
  input  logic       S_AXI_ARESETN,
  input  axil_addr_t awaddr,
  input  logic       awvalid,
  output logic       awready,
  input  axil_data_t wdata,
  input  axil_strb_t wstrb,
  input  logic       wvalid,
  output logic       wready,
  output logic       bvalid,
  output axil_resp_t bresp,
  input  logic       bready,
  output logic       wr_en,
  output reg_index_t wr_index,
  output axil_data_t wr_data,
  output axil_strb_t wr_strb
);

  logic       wr_accept;    // Shared AWREADY / WREADY pulse
  logic       bvalid_q;
  axil_addr_t awaddr_q;
  logic       b_free;
  logic       start;

  // B channel can take a new response at the next edge
  assign b_free = !bvalid_q || bready;

  // Both halves of the write present, no pulse in flight
  assign start = !wr_accept && awvalid && wvalid && b_free;

  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      wr_accept <= 1'b0;
    end else begin
      wr_accept <= start;   // High for exactly one cycle
    end
  end

  // Address held for the ready cycle
  always_ff @(posedge S_AXI_ACLK) begin
    if (start) begin
      awaddr_q <= awaddr;
    end
  end

  assign awready = wr_accept;
  assign wready  = wr_accept;

  // AW and W transfer at the same edge
  assign wr_en = wr_accept && awvalid && wvalid;

  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      bvalid_q <= 1'b0;
    end else begin
      if (wr_en) begin
        bvalid_q <= 1'b1;
      end else if (bready) begin
        bvalid_q <= 1'b0;   // Response taken
      end
    end
  end

  assign bvalid = bvalid_q;
  assign bresp  = OKAY;   // Every register write succeeds

  // Write command to the bank, data straight off the W channel
  assign wr_index = awaddr_q[`REG_INDEX_LSB +: $bits(reg_index_t)];
  assign wr_data  = wdata;
  assign wr_strb  = wstrb;

endmodule

// File: verilog/reg_bank_pkg.sv
`include "axil_reg_settings.svh"

package reg_bank_pkg;

  // Register number, sliced from the byte address
  typedef logic [$clog2(`REG_COUNT)-1:0] reg_index_t;

  // One register word, seen whole or as byte lanes
  typedef union packed {
    axi_lite_pkg::axil_data_t            word;
    logic [`AXIL_STRB_WIDTH-1:0][7:0]    bytes;   // Lane 0 is bits 7:0
  } reg_word_u;

endpackage

// File: verilog/axi_lite_pkg.sv
`include "axil_reg_settings.svh"

package axi_lite_pkg;

  typedef logic [`AXIL_ADDR_WIDTH-1:0] axil_addr_t;   // Byte address
  typedef logic [`AXIL_DATA_WIDTH-1:0] axil_data_t;
  typedef logic [`AXIL_STRB_WIDTH-1:0] axil_strb_t;   // One bit per byte lane

  // Response codes on BRESP and RRESP
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    EXOKAY = 2'b01,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } axil_resp_t;

endpackage

// File: verilog/axil_reg_settings.svh
`ifndef AXIL_REG_SETTINGS_SVH
`define AXIL_REG_SETTINGS_SVH

// AXI4-Lite bus widths
`define AXIL_DATA_WIDTH 32
`define AXIL_ADDR_WIDTH 7
`define AXIL_STRB_WIDTH (`AXIL_DATA_WIDTH / 8)

// Register bank geometry
`define REG_COUNT 32
`define REG_INDEX_LSB 2   // Word aligned, byte offset dropped

`endif
